// ==== testbench/nandDataOutTrace.txt ====
// first entry: record count; each record: way, byte count,
// then one data word and one valid delay per word (delay ffff is random 0..7)
0004
// way 0, four bytes
0001 0004
a1b2 0000
c3d4 0003
// way 1, odd count ends on an upper byte
0002 0003
1234 0000
5678 0002
// way 3, random stalls
0008 0006
dead ffff
beef ffff
0f0f ffff
// way 2, single byte
0004 0001
9a5c 0001

// ==== filelist.f ====
+incdir+include
source/nandDataOutPkg.sv
source/commandLatch.sv
source/wordFetch.sv
source/byteSerializer.sv
source/nandDataOut.sv
testbench/clockGen.sv
testbench/nandDataOutTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f filelist.f --top-module nandDataOutTb -o simNandDataOut
./obj_dir/simNandDataOut

// ==== testbench/nandDataOutTb.sv ====
`timescale 1ns/100ps
`include "nandDataOut_config.svh"

module nandDataOutTb;

    localparam int TraceDepth = 64;
    localparam int MaxDelay   = 8;

    logic                     iSystemClock;
    logic                     rst;
    logic                     iStart;
    logic [`NUM_WAYS-1:0]     targetWay;
    logic [`COUNT_WIDTH-1:0]  numOfData;
    logic [`WORD_WIDTH-1:0]   writeData;
    logic                     writeValid;
    logic                     writeReady;
    logic                     ready;
    logic                     lastStep;
    nandDataOutPkg::nandBus_t pins;

    logic [15:0]          traceMem [0:TraceDepth-1];
    int                   delays [0:TraceDepth-1]; // resolved per word entry
    logic [7:0]           expected [$];
    logic [7:0]           captured [$];
    logic [`NUM_WAYS-1:0] curWay;
    logic                 busy;
    logic [3:0]           prevWe = 4'b0000;
    int                   weRun = 0;
    int                   lastCount = 0;
    int                   cycleCount = 0;
    int                   cycleLimit;

    clockGen uClock (.iSystemClock(iSystemClock), .rst(rst));

    nandDataOut dut (
        .iSystemClock(iSystemClock),
        .rst(rst),
        .iStart(iStart),
        .targetWay(targetWay),
        .numOfData(numOfData),
        .writeData(writeData),
        .writeValid(writeValid),
        .writeReady(writeReady),
        .ready(ready),
        .lastStep(lastStep),
        .pins(pins)
    );

    task automatic reportMismatch(input string testName, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("TESTBENCH FAILED");
        $display("ERR %s expected %0h actual %0h", testName, exp, act);
        $fatal(1);
    endtask

    // pin monitor, bytes are taken when the write enable pulse ends
    always @(negedge iSystemClock) begin
        if (!rst) begin
            if (pins.writeEnable == `WE_ACTIVE_PATTERN) begin
                assert (pins.dq == {16'h0, pins.dq[7:0], pins.dq[7:0]})
                    else reportMismatch("dqLanes", {16'h0, pins.dq[7:0], pins.dq[7:0]}, pins.dq);
                assert (pins.chipEnable == {curWay, curWay})
                    else reportMismatch("chipEnable", 32'({curWay, curWay}),
                                        32'(pins.chipEnable));
                weRun++;
            end else begin
                assert (pins.writeEnable == 4'b0000)
                    else reportMismatch("weIdle", 0, 32'(pins.writeEnable));
                if (prevWe == `WE_ACTIVE_PATTERN) begin
                    assert (weRun == `WE_ACTIVE_CYCLES)
                        else reportMismatch("weRun", `WE_ACTIVE_CYCLES, weRun);
                    captured.push_back(pins.dq[7:0]);
                end
                weRun = 0;
            end
            if (ready) begin
                assert (pins.chipEnable == '0)
                    else reportMismatch("chipEnableIdle", 0, 32'(pins.chipEnable));
            end
            if (busy) begin
                assert (ready == 1'b0) else reportMismatch("readyBusy", 0, 32'(ready));
            end
            if (lastStep) begin
                lastCount++;
            end
            prevWe = pins.writeEnable;
        end
    end

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("TESTBENCH FAILED");
            $display("timeout, transfers still running after %0d cycles", cycleCount);
            $fatal(1);
        end
    end

    initial begin
        int numRecords;
        int rec;
        int idx;
        int count;
        int words;
        int base;
        int w;
        logic [31:0] heldDq;
        iStart     = 1'b0;
        targetWay  = '0;
        numOfData  = '0;
        writeData  = '0;
        writeValid = 1'b0;
        busy      <= 1'b0;
        curWay    <= '0;
        cycleLimit = 100; // reset and start-up
        void'($urandom(32'h85bf));
        $readmemh("testbench/nandDataOutTrace.txt", traceMem);
        numRecords = int'(traceMem[0]);
        idx = 1;
        for (rec = 0; rec < numRecords; rec++) begin
            count = int'(traceMem[idx+1]);
            cycleLimit += `SETUP_CYCLES + count * `BYTE_CYCLES + 20;
            idx += 2;
            for (w = 0; w < (count + 1) / 2; w++) begin
                if (traceMem[idx+1] == 16'hffff) begin
                    delays[idx+1] = int'($urandom % MaxDelay);
                end else begin
                    delays[idx+1] = int'(traceMem[idx+1]);
                end
                cycleLimit += delays[idx+1] + 6;
                idx += 2;
            end
        end

        @(negedge iSystemClock);
        idx = 1;
        for (rec = 0; rec < numRecords; rec++) begin
            while (rst || ready !== 1'b1) @(negedge iSystemClock);
            count = int'(traceMem[idx+1]);
            words = (count + 1) / 2;
            base  = captured.size();
            expected.delete();
            for (w = 0; w < words; w++) begin
                expected.push_back(traceMem[idx+2+2*w][15:8]); // upper byte first
                if (2 * w + 1 < count) begin
                    expected.push_back(traceMem[idx+2+2*w][7:0]);
                end
            end
            targetWay = traceMem[idx][`NUM_WAYS-1:0];
            numOfData = traceMem[idx+1];
            iStart    = 1'b1;
            curWay   <= traceMem[idx][`NUM_WAYS-1:0];
            @(negedge iSystemClock);
            iStart = 1'b0;
            assert (ready == 1'b0) else reportMismatch("startAccept", 0, 32'(ready));
            busy <= 1'b1;
            idx += 2;
            for (w = 0; w < words; w++) begin
                if (w == 0) begin
                    while (pins.chipEnable == '0) @(negedge iSystemClock);
                    repeat (`SETUP_CYCLES) @(negedge iSystemClock); // first request after setup
                end else begin
                    while (captured.size() < base + 2 * w) @(posedge iSystemClock);
                    repeat (`BYTE_CYCLES - `WE_ACTIVE_CYCLES) @(negedge iSystemClock); // rest of lower byte
                end
                repeat (delays[idx+1]) begin
                    @(negedge iSystemClock);
                    assert (pins.writeEnable == 4'b0000)
                        else reportMismatch("weStall", 0, 32'(pins.writeEnable));
                    if (w > 0) begin
                        heldDq = {16'h0, expected[2*w-1], expected[2*w-1]};
                        assert (pins.dq == heldDq)
                            else reportMismatch("dqStall", heldDq, pins.dq);
                    end
                end
                assert (writeReady == 1'b0)
                    else reportMismatch("readyBeforeValid", 0, 32'(writeReady));
                writeData  = traceMem[idx];
                writeValid = 1'b1;
                @(negedge iSystemClock);
                while (writeReady !== 1'b1) @(negedge iSystemClock);
                @(negedge iSystemClock); // word moved on the edge before
                writeValid = 1'b0;
                writeData  = '0;
                assert (writeReady == 1'b0)
                    else reportMismatch("readyPulse", 0, 32'(writeReady));
                idx += 2;
            end
            while (lastStep !== 1'b1) @(negedge iSystemClock);
            busy <= 1'b0;
            assert (captured.size() - base == count)
                else reportMismatch("byteCount", count, captured.size() - base);
            foreach (expected[i]) begin
                assert (captured[base+i] == expected[i])
                    else reportMismatch("byteOrder", 32'(expected[i]), 32'(captured[base+i]));
            end
            @(negedge iSystemClock);
            assert (ready == 1'b1) else reportMismatch("readyReturn", 1, 32'(ready));
        end
        assert (lastCount == numRecords) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            reportMismatch("lastStepCount", numRecords, lastCount);
        end
    end

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic iSystemClock,
    output logic rst
);

    initial begin
        iSystemClock = 1'b0;
        forever #4 iSystemClock = ~iSystemClock; // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge iSystemClock);
        @(negedge iSystemClock);
        rst = 1'b0; // released on a falling edge
    end

endmodule

// ==== source/nandDataOut.sv ====
`timescale 1ns/100ps
`include "nandDataOut_config.svh"

module nandDataOut (
    input  logic                     iSystemClock,
    input  logic                     rst,
    input  logic                     iStart,
    input  logic [`NUM_WAYS-1:0]     targetWay,
    input  logic [`COUNT_WIDTH-1:0]  numOfData,
    input  logic [`WORD_WIDTH-1:0]   writeData,
    input  logic                     writeValid,
    output logic                     writeReady,
    output logic                     ready,
    output logic                     lastStep,
    output nandDataOutPkg::nandBus_t pins
);

    nandDataOutPkg::xferCmd_t cmd;
    logic                     setupDone;
    logic                     wordRequest;
    logic                     wordStrobe;
    logic                     xferDone;
    logic [`WORD_WIDTH-1:0]   word;
    logic [2*`NUM_WAYS-1:0]   chipEnable;
    logic [3:0]               writeEnable;
    logic [`DQ_WIDTH-1:0]     dq;

    commandLatch uLatch (
        .iSystemClock(iSystemClock),
        .rst(rst),
        .iStart(iStart),
        .targetWay(targetWay),
        .numOfData(numOfData),
        .xferDone(xferDone),
        .ready(ready),
        .lastStep(lastStep),
        .setupDone(setupDone),
        .cmd(cmd),
        .chipEnable(chipEnable)
    );

    wordFetch uFetch (
        .iSystemClock(iSystemClock),
        .rst(rst),
        .setupDone(setupDone),
        .wordRequest(wordRequest),
        .writeData(writeData),
        .writeValid(writeValid),
        .writeReady(writeReady),
        .wordStrobe(wordStrobe),
        .word(word)
    );

    byteSerializer uSerializer (
        .iSystemClock(iSystemClock),
        .rst(rst),
        .cmd(cmd),
        .wordStrobe(wordStrobe),
        .word(word),
        .wordRequest(wordRequest),
        .xferDone(xferDone),
        .writeEnable(writeEnable),
        .dq(dq)
    );

    assign pins = '{chipEnable: chipEnable, writeEnable: writeEnable, dq: dq};

endmodule

// ==== source/byteSerializer.sv ====
`timescale 1ns/100ps
`include "nandDataOut_config.svh"

module byteSerializer (
    input  logic                     iSystemClock,
    input  logic                     rst,
    input  nandDataOutPkg::xferCmd_t cmd,
    input  logic                     wordStrobe,
    input  logic [`WORD_WIDTH-1:0]   word,
    output logic                     wordRequest,
    output logic                     xferDone,
    output logic [3:0]               writeEnable,
    output logic [`DQ_WIDTH-1:0]     dq
);

    localparam int ByteWidth  = `WORD_WIDTH / 2;
    localparam int PadWidth   = `DQ_WIDTH - `WORD_WIDTH;
    localparam int TimerWidth = $clog2(`BYTE_CYCLES);

    nandDataOutPkg::serState_t state;
    logic [TimerWidth-1:0]     byteTimer;
    logic [`COUNT_WIDTH-1:0]   byteCount;
    logic [ByteWidth-1:0]      heldLower;
    logic                      periodEnd;
    logic                      lastByte;

    // byte on both low lanes, upper half zero
    function automatic logic [`DQ_WIDTH-1:0] laneCopy(input logic [ByteWidth-1:0] value);
        return {{PadWidth{1'b0}}, value, value};
    endfunction

    assign periodEnd = (byteTimer == TimerWidth'(`BYTE_CYCLES - 1));
    assign lastByte  = ((byteCount + 1'b1) == cmd.numOfData);

    assign writeEnable = (state != nandDataOutPkg::ssWaitWord &&
                          byteTimer < TimerWidth'(`WE_ACTIVE_CYCLES)) ?
                         `WE_ACTIVE_PATTERN : 4'b0000;

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            state       <= nandDataOutPkg::ssWaitWord;
            byteTimer   <= '0;
            byteCount   <= '0;
            wordRequest <= 1'b0;
            xferDone    <= 1'b0;
            dq          <= '0;
        end else begin
            wordRequest <= 1'b0;
            xferDone    <= 1'b0;
            case (state)
                nandDataOutPkg::ssWaitWord: begin
                    if (wordStrobe) begin
                        byteTimer <= '0;
                        dq        <= laneCopy(word[`WORD_WIDTH-1:ByteWidth]); // upper first
                        state     <= nandDataOutPkg::ssUpperByte;
                    end
                end
                nandDataOutPkg::ssUpperByte: begin
                    if (periodEnd) begin
                        byteTimer <= '0;
                        if (lastByte) begin // odd count ends here
                            byteCount <= '0;
                            xferDone  <= 1'b1;
                            state     <= nandDataOutPkg::ssWaitWord;
                        end else begin
                            byteCount <= byteCount + 1'b1;
                            dq        <= laneCopy(heldLower);
                            state     <= nandDataOutPkg::ssLowerByte;
                        end
                    end else begin
                        byteTimer <= byteTimer + 1'b1;
                    end
                end
                nandDataOutPkg::ssLowerByte: begin
                    if (periodEnd) begin
                        byteTimer <= '0;
                        state     <= nandDataOutPkg::ssWaitWord;
                        if (lastByte) begin
                            byteCount <= '0;
                            xferDone  <= 1'b1;
                        end else begin
                            byteCount   <= byteCount + 1'b1;
                            wordRequest <= 1'b1; // dq holds while next word comes
                        end
                    end else begin
                        byteTimer <= byteTimer + 1'b1;
                    end
                end
                default: state <= nandDataOutPkg::ssWaitWord;
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (state == nandDataOutPkg::ssWaitWord && wordStrobe) begin
            heldLower <= word[ByteWidth-1:0];
        end
    end

endmodule

// ==== source/wordFetch.sv ====
`timescale 1ns/100ps
`include "nandDataOut_config.svh"

module wordFetch (
    input  logic                    iSystemClock,
    input  logic                    rst,
    input  logic                    setupDone,
    input  logic                    wordRequest,
    input  logic [`WORD_WIDTH-1:0]  writeData,
    input  logic                    writeValid,
    output logic                    writeReady,
    output logic                    wordStrobe,
    output logic [`WORD_WIDTH-1:0]  word
);

    nandDataOutPkg::fetchState_t state;
    logic                        transfer;

    assign transfer   = writeValid && writeReady;
    assign wordStrobe = (state == nandDataOutPkg::fsHandOver);

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            state      <= nandDataOutPkg::fsWaitRequest;
            writeReady <= 1'b0;
        end else begin
            case (state)
                nandDataOutPkg::fsWaitRequest: begin
                    if (setupDone || wordRequest) begin // first word or next word
                        state <= nandDataOutPkg::fsWaitValid;
                    end
                end
                nandDataOutPkg::fsWaitValid: begin
                    if (transfer) begin
                        writeReady <= 1'b0;
                        state      <= nandDataOutPkg::fsHandOver;
                    end else begin
                        writeReady <= writeValid; // one cycle after valid seen
                    end
                end
                nandDataOutPkg::fsHandOver: begin
                    state <= nandDataOutPkg::fsWaitRequest;
                end
                default: begin
                    writeReady <= 1'b0;
                    state      <= nandDataOutPkg::fsWaitRequest;
                end
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (transfer) begin
            word <= writeData;
        end
    end

    // source must hold valid and data until ready arrives
    validHeld: assert property (@(posedge iSystemClock) disable iff (rst)
        (state == nandDataOutPkg::fsWaitValid && writeValid && !writeReady)
        |=> writeValid && $stable(writeData));

endmodule

// ==== source/commandLatch.sv ====
`timescale 1ns/100ps
`include "nandDataOut_config.svh"

module commandLatch (
    input  logic                     iSystemClock,
    input  logic                     rst,
    input  logic                     iStart,
    input  logic [`NUM_WAYS-1:0]     targetWay,
    input  logic [`COUNT_WIDTH-1:0]  numOfData,
    input  logic                     xferDone,
    output logic                     ready,
    output logic                     lastStep,
    output logic                     setupDone,
    output nandDataOutPkg::xferCmd_t cmd,
    output logic [2*`NUM_WAYS-1:0]   chipEnable
);

    localparam int SetupWidth = $clog2(`SETUP_CYCLES);

    nandDataOutPkg::latchState_t state;
    logic [SetupWidth-1:0]       setupCount;
    logic                        startAccept;

    assign startAccept = (state == nandDataOutPkg::lsIdle) && ready && iStart;

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            state      <= nandDataOutPkg::lsIdle;
            ready      <= 1'b0;
            lastStep   <= 1'b0;
            setupDone  <= 1'b0;
            setupCount <= '0;
            chipEnable <= '0;
        end else begin
            setupDone <= 1'b0; // pulses
            lastStep  <= 1'b0;
            case (state)
                nandDataOutPkg::lsIdle: begin
                    ready <= 1'b1; // first idle cycle after reset stays low
                    if (startAccept) begin
                        ready <= 1'b0;
                        state <= nandDataOutPkg::lsLatch;
                    end
                end
                nandDataOutPkg::lsLatch: begin
                    chipEnable <= {cmd.way, cmd.way}; // both halves
                    setupCount <= '0;
                    state      <= nandDataOutPkg::lsSetup;
                end
                nandDataOutPkg::lsSetup: begin
                    if (setupCount == SetupWidth'(`SETUP_CYCLES - 1)) begin
                        setupDone <= 1'b1;
                        state     <= nandDataOutPkg::lsBusy;
                    end else begin
                        setupCount <= setupCount + 1'b1;
                    end
                end
                nandDataOutPkg::lsBusy: begin
                    if (xferDone) begin
                        lastStep   <= 1'b1;
                        chipEnable <= '0; // drops with lastStep
                        state      <= nandDataOutPkg::lsLast;
                    end
                end
                nandDataOutPkg::lsLast: begin
                    ready <= 1'b1;
                    state <= nandDataOutPkg::lsIdle;
                end
                default: state <= nandDataOutPkg::lsIdle;
            endcase
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (startAccept) begin
            cmd <= '{way: targetWay, numOfData: numOfData};
        end
    end

    // serializer compares against count, zero would never match
    zeroCountStart: assert property (@(posedge iSystemClock) disable iff (rst)
        startAccept |-> numOfData != '0);

    singleLastStep: assert property (@(posedge iSystemClock) disable iff (rst)
        lastStep |=> !lastStep);

endmodule

// ==== source/nandDataOutPkg.sv ====
`include "nandDataOut_config.svh"

package nandDataOutPkg;

    // captured at start, held for the whole transfer
    typedef struct packed {
        logic [`NUM_WAYS-1:0]    way;
        logic [`COUNT_WIDTH-1:0] numOfData;
    } xferCmd_t;

    typedef struct packed {
        logic [2*`NUM_WAYS-1:0] chipEnable;
        logic [3:0]             writeEnable;
        logic [`DQ_WIDTH-1:0]   dq;
    } nandBus_t;

    typedef enum logic [2:0] {
        lsIdle,
        lsLatch,
        lsSetup,
        lsBusy,
        lsLast
    } latchState_t;

    typedef enum logic [1:0] {
        fsWaitRequest,
        fsWaitValid,
        fsHandOver
    } fetchState_t;

    typedef enum logic [1:0] {
        ssWaitWord,
        ssUpperByte,
        ssLowerByte
    } serState_t;

endpackage

// ==== include/nandDataOut_config.svh ====
`ifndef NAND_DATA_OUT_CONFIG_SVH
`define NAND_DATA_OUT_CONFIG_SVH

// NAND way count, chip enable carries two halves per way
`define NUM_WAYS 4

`define WORD_WIDTH 16
`define COUNT_WIDTH 16
`define DQ_WIDTH 32

// chip enable held this long before the first word
`define SETUP_CYCLES 10

// one byte on the pins
`define BYTE_CYCLES 10

// write enable pulse at the start of each byte period
`define WE_ACTIVE_CYCLES 5
`define WE_ACTIVE_PATTERN 4'b0011

`endif
